// File: filelist.f
+incdir+source
source/mem_pkg.sv
source/wb_bus_if.sv
source/lsu.sv
source/fetch_port.sv
source/wb_arbiter.sv
source/data_ram.sv
source/mem_stage_top.sv
verification/mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/wb_bus_if.sv
      - source/lsu.sv
      - source/fetch_port.sv
      - source/wb_arbiter.sv
      - source/data_ram.sv
      - source/mem_stage_top.sv
  - target: test
    files:
      - verification/mem_stage_tb.sv

// File: verification/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int ENTRY_TIMEOUT = 40;
    localparam logic [31:0] FETCH_BASE = 32'h0000_0040;

    typedef struct {
        mem_pkg::ls_sel_e sel;
        logic [31:0]      addr;
        logic [31:0]      rt;
        logic [4:0]       dst;
        logic             fetch;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic [3:0]  req_sel;
    logic [31:0] req_addr;
    logic [31:0] req_rt_data;
    logic [4:0]  req_w_reg_dst;
    logic        req_ready;
    logic        done;
    logic        misaligned;
    logic [31:0] r_data;
    logic [4:0]  w_reg_dst;
    logic        w_reg_ena;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic        fetch_ready;
    logic        fetch_done;
    logic [31:0] fetch_instr;

    entry_t      tbl[$];
    logic [7:0]  model_mem [0:255];
    logic        fetch_en;
    logic        fetch_stop;
    logic        fetch_busy;
    int          lsu_errors;
    int          fetch_errors;

    mem_stage_top mem_stage_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_sel       (req_sel),
        .req_addr      (req_addr),
        .req_rt_data   (req_rt_data),
        .req_w_reg_dst (req_w_reg_dst),
        .req_ready     (req_ready),
        .done          (done),
        .misaligned    (misaligned),
        .r_data        (r_data),
        .w_reg_dst     (w_reg_dst),
        .w_reg_ena     (w_reg_ena),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_ready   (fetch_ready),
        .fetch_done    (fetch_done),
        .fetch_instr   (fetch_instr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================
    function automatic logic breaks_alignment(mem_pkg::ls_sel_e sel, logic [31:0] addr);
        case (sel)
            mem_pkg::LS_LH, mem_pkg::LS_LHU, mem_pkg::LS_SH: return addr[0];
            mem_pkg::LS_LW, mem_pkg::LS_SW:                  return addr[1:0] != 2'b00;
            default:                                         return 1'b0;
        endcase
    endfunction

    function automatic logic reads_reg(mem_pkg::ls_sel_e sel);
        case (sel)
            mem_pkg::LS_SB, mem_pkg::LS_SH, mem_pkg::LS_SW, mem_pkg::LS_NONE: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] model_word(logic [31:0] addr);
        int a;
        a = int'({addr[7:2], 2'b00});
        return {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]};
    endfunction

    function automatic logic [31:0] expect_load(mem_pkg::ls_sel_e sel, logic [31:0] addr,
                                                logic [31:0] rt);
        int          a;
        int          base;
        int          off;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] res;
        a    = int'(addr[7:0]);
        base = a - (a % 4);
        off  = a % 4;
        b    = model_mem[a];
        h    = {model_mem[a + 1], model_mem[a]};
        res  = rt;
        case (sel)
            mem_pkg::LS_LB:  res = {{24{b[7]}}, b};
            mem_pkg::LS_LBU: res = {24'h000000, b};
            mem_pkg::LS_LH:  res = {{16{h[15]}}, h};
            mem_pkg::LS_LHU: res = {16'h0000, h};
            mem_pkg::LS_LW:  res = model_word(addr);
            // Bytes up to addr go to the top of rt.
            mem_pkg::LS_LWL: begin
                for (int i = 0; i <= off; i++) begin
                    res[8*(3-off+i) +: 8] = model_mem[base + i];
                end
            end
            // Bytes from addr on go to the bottom of rt.
            mem_pkg::LS_LWR: begin
                for (int i = off; i < 4; i++) begin
                    res[8*(i-off) +: 8] = model_mem[base + i];
                end
            end
            default: res = 'x;
        endcase
        return res;
    endfunction

    task automatic apply_store(mem_pkg::ls_sel_e sel, logic [31:0] addr, logic [31:0] rt);
        int a;
        int n;
        a = int'(addr[7:0]);
        case (sel)
            mem_pkg::LS_SB: n = 1;
            mem_pkg::LS_SH: n = 2;
            mem_pkg::LS_SW: n = 4;
            default:        n = 0;
        endcase
        for (int i = 0; i < n; i++) begin
            model_mem[a + i] = rt[8*i +: 8];
        end
    endtask

    task automatic add_entry(mem_pkg::ls_sel_e sel, logic [31:0] addr, logic [31:0] rt,
                             logic fetch);
        entry_t e;
        e.sel   = sel;
        e.addr  = addr;
        e.rt    = rt;
        e.dst   = 5'(tbl.size() % 31 + 1);
        e.fetch = fetch;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // Data words, then the fetch region.
        add_entry(mem_pkg::LS_SW, 32'h00, 32'h8477_F1A2, 1'b0);
        add_entry(mem_pkg::LS_SW, 32'h04, 32'h1234_5678, 1'b0);
        add_entry(mem_pkg::LS_SW, 32'h08, 32'hCAFE_0BAD, 1'b0);
        add_entry(mem_pkg::LS_SW, 32'h0C, 32'h7F80_FF01, 1'b0);
        add_entry(mem_pkg::LS_SW, 32'h40, 32'h2402_0001, 1'b0);
        add_entry(mem_pkg::LS_SW, 32'h44, 32'h8C83_0004, 1'b0);
        add_entry(mem_pkg::LS_SW, 32'h48, 32'hAC85_FFFC, 1'b0);
        add_entry(mem_pkg::LS_SW, 32'h4C, 32'h1000_FFFF, 1'b0);
        for (int i = 0; i < 4; i++) begin
            add_entry(mem_pkg::LS_LB, 32'(i), 32'h0, 1'b1);
            add_entry(mem_pkg::LS_LBU, 32'(i), 32'h0, 1'b1);
        end
        add_entry(mem_pkg::LS_LH, 32'h00, 32'h0, 1'b1);
        add_entry(mem_pkg::LS_LH, 32'h0E, 32'h0, 1'b1);
        add_entry(mem_pkg::LS_LHU, 32'h00, 32'h0, 1'b1);
        add_entry(mem_pkg::LS_LHU, 32'h0E, 32'h0, 1'b1);
        add_entry(mem_pkg::LS_SB, 32'h04, 32'h0000_00E7, 1'b1);
        add_entry(mem_pkg::LS_SB, 32'h05, 32'h0000_00A5, 1'b1);
        add_entry(mem_pkg::LS_SB, 32'h06, 32'h1234_5600, 1'b1);
        add_entry(mem_pkg::LS_SB, 32'h07, 32'hFFFF_FF3C, 1'b1);
        add_entry(mem_pkg::LS_SH, 32'h08, 32'h1111_BEEF, 1'b1);
        add_entry(mem_pkg::LS_SH, 32'h0A, 32'h0000_8001, 1'b1);
        add_entry(mem_pkg::LS_LW, 32'h04, 32'h0, 1'b1);
        add_entry(mem_pkg::LS_LW, 32'h08, 32'h0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            add_entry(mem_pkg::LS_LWL, 32'(i), 32'hDEAD_BEEF, 1'b1);
            add_entry(mem_pkg::LS_LWR, 32'(12 + i), 32'h0123_4567, 1'b1);
        end
        // Refused accesses leave memory as it was.
        add_entry(mem_pkg::LS_LH, 32'h01, 32'h0, 1'b1);
        add_entry(mem_pkg::LS_LHU, 32'h03, 32'h0, 1'b1);
        add_entry(mem_pkg::LS_SH, 32'h05, 32'h0000_FFFF, 1'b1);
        add_entry(mem_pkg::LS_SW, 32'h0E, 32'h5555_AAAA, 1'b1);
        add_entry(mem_pkg::LS_LW, 32'h06, 32'h0, 1'b1);
        add_entry(mem_pkg::LS_LW, 32'h04, 32'h0, 1'b1);
        add_entry(mem_pkg::LS_LW, 32'h0C, 32'h0, 1'b1);
    endtask

    // ====================
    // LSU entry
    // ====================
    task automatic run_entry(int idx);
        entry_t      e;
        logic        exp_mis;
        logic        exp_ena;
        logic [31:0] exp_data;
        int          n;
        e        = tbl[idx];
        exp_mis  = breaks_alignment(e.sel, e.addr);
        exp_ena  = reads_reg(e.sel) && !exp_mis;
        exp_data = expect_load(e.sel, e.addr, e.rt);
        @(posedge clk);
        req_valid     <= 1'b1;
        req_sel       <= 4'(e.sel);
        req_addr      <= e.addr;
        req_rt_data   <= e.rt;
        req_w_reg_dst <= e.dst;
        fetch_en      <= e.fetch;
        @(posedge clk);
        assert (req_ready) else begin
            lsu_errors++;
            $display("LSU was not ready to accept entry %0d", idx);
        end
        req_valid <= 1'b0;
        n = 0;
        while (!done && n < ENTRY_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        assert (done) else begin
            lsu_errors++;
            $display("LSU gave no done for entry %0d within %0d cycles", idx, ENTRY_TIMEOUT);
        end
        if (done) begin
            assert (misaligned === exp_mis) else begin
                lsu_errors++;
                $display("Error: misaligned got 0x%0h expected 0x%0h, entry %0d",
                         misaligned, exp_mis, idx);
            end
            assert (w_reg_ena === exp_ena) else begin
                lsu_errors++;
                $display("Error: w_reg_ena got 0x%0h expected 0x%0h, entry %0d",
                         w_reg_ena, exp_ena, idx);
            end
            assert (w_reg_dst === e.dst) else begin
                lsu_errors++;
                $display("Error: w_reg_dst got 0x%02h expected 0x%02h, entry %0d",
                         w_reg_dst, e.dst, idx);
            end
            if (exp_ena) begin
                assert (r_data === exp_data) else begin
                    lsu_errors++;
                    $display("Error: r_data got 0x%08h expected 0x%08h, entry %0d",
                             r_data, exp_data, idx);
                end
            end
            if (!exp_mis) begin
                apply_store(e.sel, e.addr, e.rt);
            end
        end
    endtask

    initial begin : main
        int n;
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req_sel       = 4'h0;
        req_addr      = '0;
        req_rt_data   = '0;
        req_w_reg_dst = '0;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        fetch_en      = 1'b0;
        fetch_stop    = 1'b0;
        fetch_busy    = 1'b0;
        lsu_errors    = 0;
        fetch_errors  = 0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = 'x;
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            run_entry(i);
        end
        // Let a fetch in flight drain.
        fetch_stop = 1'b1;
        fetch_en <= 1'b0;
        repeat (2) @(posedge clk);
        n = 0;
        while (fetch_busy && n < ENTRY_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        $display("Errors: %0d load/store, %0d fetch", lsu_errors, fetch_errors);
        if (lsu_errors + fetch_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ====================
    // Fetch traffic
    // ====================
    initial begin : fetch_traffic
        logic [31:0] pc;
        int          n;
        void'($urandom(32'h90a8_d2e3));
        @(posedge rst_n);
        while (!fetch_stop) begin
            @(posedge clk);
            if (fetch_en && ($urandom % 3 == 0)) begin
                fetch_busy = 1'b1;
                pc = FETCH_BASE + ($urandom % 16);
                fetch_valid <= 1'b1;
                fetch_pc    <= pc;
                @(posedge clk);
                assert (fetch_ready) else begin
                    fetch_errors++;
                    $display("Fetch port was not ready to accept pc 0x%08h", pc);
                end
                fetch_valid <= 1'b0;
                n = 0;
                while (!fetch_done && n < ENTRY_TIMEOUT) begin
                    @(posedge clk);
                    n++;
                end
                assert (fetch_done) else begin
                    fetch_errors++;
                    $display("Fetch at 0x%08h never completed", pc);
                end
                if (fetch_done) begin
                    assert (fetch_instr === model_word(pc)) else begin
                        fetch_errors++;
                        $display("Error: fetch_instr got 0x%08h expected 0x%08h, pc 0x%08h",
                                 fetch_instr, model_word(pc), pc);
                    end
                end
                fetch_busy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = tbl.size() * ENTRY_TIMEOUT + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: source/mem_stage_top.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // Load/store request.
    input  logic                   req_valid,
    input  logic [3:0]             req_sel,
    input  logic [`MEM_ADDR_W-1:0] req_addr,
    input  logic [`MEM_DATA_W-1:0] req_rt_data,
    input  logic [4:0]             req_w_reg_dst,
    output logic                   req_ready,

    // Load/store result.
    output logic                   done,
    output logic                   misaligned,
    output logic [`MEM_DATA_W-1:0] r_data,
    output logic [4:0]             w_reg_dst,
    output logic                   w_reg_ena,

    // Instruction fetch.
    input  logic                   fetch_valid,
    input  logic [`MEM_ADDR_W-1:0] fetch_pc,
    output logic                   fetch_ready,
    output logic                   fetch_done,
    output logic [`MEM_DATA_W-1:0] fetch_instr
);

    mem_pkg::ls_req_s req;

    wb_bus_if lsu_bus ();
    wb_bus_if fetch_bus ();
    wb_bus_if ram_bus ();

    always_comb begin
        req.sel       = mem_pkg::ls_sel_e'(req_sel);
        req.addr      = req_addr;
        req.rt_data   = req_rt_data;
        req.w_reg_dst = req_w_reg_dst;
    end

    lsu lsu_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .done       (done),
        .misaligned (misaligned),
        .r_data     (r_data),
        .w_reg_dst  (w_reg_dst),
        .w_reg_ena  (w_reg_ena),
        .bus        (lsu_bus.master)
    );

    fetch_port fetch_port_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_ready (fetch_ready),
        .fetch_done  (fetch_done),
        .fetch_instr (fetch_instr),
        .bus         (fetch_bus.master)
    );

    // LSU on port 0 wins the first tie.
    wb_arbiter wb_arbiter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .m0    (lsu_bus.slave),
        .m1    (fetch_bus.slave),
        .s     (ram_bus.master)
    );

    data_ram data_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (ram_bus.slave)
    );

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module data_ram (
    input  logic    clk,
    input  logic    rst_n,
    wb_bus_if.slave bus
);

    logic [`MEM_DATA_W-1:0]    mem [`MEM_DEPTH_WORDS];
    logic [`MEM_WORD_IDX_W-1:0] idx;
    logic [`MEM_DATA_W-1:0]    rd_q;
    logic [3:0]                wait_cnt;
    logic                      ack_q;
    logic                      ack_set;

    // Word index from byte address.
    assign idx = bus.adr[`MEM_WORD_IDX_W+1:2];

    // One ack per strobe, after the wait states.
    assign ack_set = bus.cyc && bus.stb && !ack_q && (wait_cnt == 4'(`MEM_RAM_WAIT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            wait_cnt <= '0;
        end else begin
            ack_q <= ack_set;
            if (!bus.stb || ack_q || ack_set) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 4'd1;
            end
        end
    end

    // Write lanes and read word on the ack edge.
    always_ff @(posedge clk) begin
        if (ack_set) begin
            if (bus.we) begin
                for (int i = 0; i < `MEM_SEL_W; i++) begin
                    if (bus.sel[i]) begin
                        mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
                    end
                end
            end
            rd_q <= mem[idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = rd_q;

endmodule

// File: source/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic     clk,
    input  logic     rst_n,
    wb_bus_if.slave  m0,
    wb_bus_if.slave  m1,
    wb_bus_if.master s
);

    logic [1:0] req;
    logic [1:0] pick;
    logic [1:0] gnt;
    logic [1:0] gnt_q;
    logic       last_m1;

    assign req = {m1.cyc, m0.cyc};

    // On a tie, serve whoever waited last.
    always_comb begin
        if (req == 2'b11) begin
            pick = last_m1 ? 2'b01 : 2'b10;
        end else begin
            pick = req;
        end
    end

    // Owner holds the bus until its cyc drops.
    assign gnt = (gnt_q != 2'b00) ? gnt_q : pick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q   <= 2'b00;
            last_m1 <= 1'b1;
        end else begin
            gnt_q <= gnt & req;
            if ((gnt_q == 2'b00) && (gnt != 2'b00)) begin
                last_m1 <= gnt[1];
            end
        end
    end

    // ====================
    // Master to slave mux
    // ====================
    always_comb begin
        s.cyc   = 1'b0;
        s.stb   = 1'b0;
        s.we    = 1'b0;
        s.adr   = '0;
        s.dat_w = '0;
        s.sel   = '0;
        if (gnt[0]) begin
            s.cyc   = m0.cyc;
            s.stb   = m0.stb;
            s.we    = m0.we;
            s.adr   = m0.adr;
            s.dat_w = m0.dat_w;
            s.sel   = m0.sel;
        end else if (gnt[1]) begin
            s.cyc   = m1.cyc;
            s.stb   = m1.stb;
            s.we    = m1.we;
            s.adr   = m1.adr;
            s.dat_w = m1.dat_w;
            s.sel   = m1.sel;
        end
    end

    // Losing master sees no ack.
    assign m0.ack   = s.ack && gnt[0];
    assign m1.ack   = s.ack && gnt[1];
    assign m0.dat_r = gnt[0] ? s.dat_r : '0;
    assign m1.dat_r = gnt[1] ? s.dat_r : '0;

    a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        s.cyc |=> (gnt == $past(gnt)));

endmodule

// File: source/fetch_port.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module fetch_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_valid,
    input  logic [`MEM_ADDR_W-1:0] fetch_pc,
    output logic                   fetch_ready,
    output logic                   fetch_done,
    output logic [`MEM_DATA_W-1:0] fetch_instr,
    wb_bus_if.master               bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_DONE
    } state_e;

    state_e                 state;
    logic [`MEM_ADDR_W-1:0] pc_q;

    assign fetch_ready = (state == ST_IDLE);
    assign fetch_done  = (state == ST_DONE);

    // Word reads only.
    assign bus.cyc   = (state == ST_BUS);
    assign bus.stb   = (state == ST_BUS);
    assign bus.we    = 1'b0;
    assign bus.adr   = pc_q;
    assign bus.sel   = '1;
    assign bus.dat_w = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (fetch_valid) state <= ST_BUS;
                ST_BUS:  if (bus.ack) state <= ST_DONE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            pc_q <= {fetch_pc[`MEM_ADDR_W-1:2], 2'b00};
        end
        if ((state == ST_BUS) && bus.ack) begin
            fetch_instr <= bus.dat_r;
        end
    end

    // A fetch stays a stable read until ack.
    a_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.cyc && !bus.ack) |=> (bus.cyc && !bus.we && $stable(bus.adr)));

endmodule

// File: source/lsu.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module lsu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  mem_pkg::ls_req_s       req,
    output logic                   req_ready,
    output logic                   done,
    output logic                   misaligned,
    output logic [`MEM_DATA_W-1:0] r_data,
    output logic [4:0]             w_reg_dst,
    output logic                   w_reg_ena,
    wb_bus_if.master               bus
);

    typedef enum logic {
        ST_IDLE,
        ST_BUS
    } state_e;

    state_e                 state;
    mem_pkg::ls_req_s       req_q;
    logic                   accept;
    logic                   bad_align;
    logic                   skip_bus;
    logic [`MEM_SEL_W-1:0]  st_sel;
    logic [`MEM_DATA_W-1:0] st_data;

    function automatic logic is_store(mem_pkg::ls_sel_e sel);
        return sel inside {mem_pkg::LS_SB, mem_pkg::LS_SH, mem_pkg::LS_SW};
    endfunction

    function automatic logic is_load(mem_pkg::ls_sel_e sel);
        return sel inside {mem_pkg::LS_LB, mem_pkg::LS_LBU, mem_pkg::LS_LH, mem_pkg::LS_LHU,
                           mem_pkg::LS_LW, mem_pkg::LS_LWL, mem_pkg::LS_LWR};
    endfunction

    // Halfwords need even, words need aligned.
    function automatic logic is_misaligned(mem_pkg::ls_sel_e sel, logic [1:0] off);
        logic half;
        logic word;
        half = sel inside {mem_pkg::LS_LH, mem_pkg::LS_LHU, mem_pkg::LS_SH};
        word = sel inside {mem_pkg::LS_LW, mem_pkg::LS_SW};
        return (half && off[0]) || (word && (off != 2'b00));
    endfunction

    function automatic logic [`MEM_DATA_W-1:0] load_extract(
        mem_pkg::ls_sel_e       sel,
        logic [1:0]             off,
        logic [`MEM_DATA_W-1:0] d,
        logic [`MEM_DATA_W-1:0] rt
    );
        logic [7:0]             b;
        logic [15:0]            h;
        logic [`MEM_DATA_W-1:0] res;
        b = d[8*off +: 8];
        h = off[1] ? d[31:16] : d[15:0];
        case (sel)
            mem_pkg::LS_LB:  res = {{24{b[7]}}, b};
            mem_pkg::LS_LBU: res = {24'h000000, b};
            mem_pkg::LS_LH:  res = {{16{h[15]}}, h};
            mem_pkg::LS_LHU: res = {16'h0000, h};
            mem_pkg::LS_LW:  res = d;
            // Memory bytes fill the high end.
            mem_pkg::LS_LWL: begin
                case (off)
                    2'b00:   res = {d[7:0], rt[23:0]};
                    2'b01:   res = {d[15:0], rt[15:0]};
                    2'b10:   res = {d[23:0], rt[7:0]};
                    default: res = d;
                endcase
            end
            // Memory bytes fill the low end.
            mem_pkg::LS_LWR: begin
                case (off)
                    2'b00:   res = d;
                    2'b01:   res = {rt[31:24], d[31:8]};
                    2'b10:   res = {rt[31:16], d[31:16]};
                    default: res = {rt[31:8], d[31:24]};
                endcase
            end
            default:         res = '0;
        endcase
        return res;
    endfunction

    assign req_ready = (state == ST_IDLE);
    assign accept    = req_valid && req_ready;
    assign bad_align = is_misaligned(req.sel, req.addr[1:0]);
    assign skip_bus  = bad_align || (req.sel == mem_pkg::LS_NONE);
    assign w_reg_dst = req_q.w_reg_dst;

    // ====================
    // Store lane steering
    // ====================
    always_comb begin
        st_sel  = 4'b1111;
        st_data = req_q.rt_data;
        case (req_q.sel)
            mem_pkg::LS_SB: begin
                st_sel  = 4'b0001 << req_q.addr[1:0];
                st_data = {4{req_q.rt_data[7:0]}};
            end
            mem_pkg::LS_SH: begin
                st_sel  = 4'b0011 << req_q.addr[1:0];
                st_data = {2{req_q.rt_data[15:0]}};
            end
            default: ;
        endcase
    end

    assign bus.cyc   = (state == ST_BUS);
    assign bus.stb   = (state == ST_BUS);
    assign bus.we    = is_store(req_q.sel);
    assign bus.adr   = {req_q.addr[`MEM_ADDR_W-1:2], 2'b00};
    assign bus.sel   = st_sel;
    assign bus.dat_w = st_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            done       <= 1'b0;
            misaligned <= 1'b0;
            w_reg_ena  <= 1'b0;
        end else begin
            done       <= 1'b0;
            misaligned <= 1'b0;
            w_reg_ena  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept && skip_bus) begin
                        done       <= 1'b1;
                        misaligned <= bad_align;
                    end else if (accept) begin
                        state <= ST_BUS;
                    end
                end
                default: begin
                    if (bus.ack) begin
                        state     <= ST_IDLE;
                        done      <= 1'b1;
                        w_reg_ena <= is_load(req_q.sel);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if ((state == ST_BUS) && bus.ack) begin
            r_data <= load_extract(req_q.sel, req_q.addr[1:0], bus.dat_r, req_q.rt_data);
        end
    end

    // Held until the slave answers.
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.cyc && !bus.ack) |=> (bus.cyc && $stable(bus.adr) && $stable(bus.we) &&
                                   $stable(bus.sel) && $stable(bus.dat_w)));

    a_ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
        bus.ack |-> bus.stb);

endmodule

// File: source/wb_bus_if.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

// Wishbone classic, single data width.
interface wb_bus_if;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`MEM_ADDR_W-1:0] adr;
    logic [`MEM_DATA_W-1:0] dat_w;
    logic [`MEM_DATA_W-1:0] dat_r;
    logic [`MEM_SEL_W-1:0]  sel;
    logic                   ack;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

    modport monitor (
        input cyc, stb, we, adr, dat_w, dat_r, sel, ack
    );
endinterface

// File: source/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    // Access kind from decode.
    typedef enum logic [3:0] {
        LS_NONE = 4'd0,
        LS_LB   = 4'd1,
        LS_LBU  = 4'd2,
        LS_LH   = 4'd3,
        LS_LHU  = 4'd4,
        LS_LW   = 4'd5,
        LS_LWL  = 4'd6,
        LS_LWR  = 4'd7,
        LS_SB   = 4'd8,
        LS_SH   = 4'd9,
        LS_SW   = 4'd10
    } ls_sel_e;

    // Execute side request.
    typedef struct packed {
        ls_sel_e                sel;
        logic [`MEM_ADDR_W-1:0] addr;
        // Store value, also the old rt for LWL/LWR.
        logic [`MEM_DATA_W-1:0] rt_data;
        logic [4:0]             w_reg_dst;
    } ls_req_s;

endpackage

// File: source/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ====================
// Bus widths
// ====================

// Data word and byte address.
`define MEM_DATA_W 32
`define MEM_ADDR_W 32

// One select bit per byte lane.
`define MEM_SEL_W (`MEM_DATA_W / 8)

// ====================
// Data RAM
// ====================

// Power of two.
`define MEM_DEPTH_WORDS 256
`define MEM_WORD_IDX_W $clog2(`MEM_DEPTH_WORDS)

// Wait states before ack.
`define MEM_RAM_WAIT 1

`endif
